/* proc_params.svh */
// Width and depth constants for the 16-bit five-stage processor
// Shared by the package and the stage modules
`ifndef PROC_PARAMS_SVH
`define PROC_PARAMS_SVH

// Data and instruction word width
`define PROC_XLEN 16

// Register file index width and register count
`define PROC_REG_AW 3
`define PROC_NREGS (1 << `PROC_REG_AW)

// Word-addressed memories
`define PROC_IMEM_AW 8
`define PROC_DMEM_AW 8
`define PROC_IMEM_DEPTH (1 << `PROC_IMEM_AW)
`define PROC_DMEM_DEPTH (1 << `PROC_DMEM_AW)

// Low bit of each instruction field
`define PROC_OP_LSB 12
`define PROC_RD_LSB 9
`define PROC_RS_LSB 6
`define PROC_RT_LSB 3

`endif

/* proc_pkg.sv */
// Types shared by the processor stages
// Word and index types, opcode and ALU encodings, pipeline register layouts
`include "proc_params.svh"

package proc_pkg;

   typedef logic [`PROC_XLEN-1:0]    word_t;
   typedef logic [`PROC_REG_AW-1:0]  reg_idx_t;
   typedef logic [`PROC_IMEM_AW-1:0] pc_t;

   // Opcode in bits 15 to 12 with unlisted values illegal
   typedef enum logic [3:0] {
      OP_NOP  = 4'd0,
      OP_ADD  = 4'd1,
      OP_SUB  = 4'd2,
      OP_AND  = 4'd3,
      OP_XOR  = 4'd4,
      OP_ADDI = 4'd5,
      OP_LD   = 4'd6,
      OP_ST   = 4'd7,
      OP_BEQZ = 4'd8,
      OP_J    = 4'd9,
      OP_HALT = 4'd15
   } opcode_e;

   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_SUB = 2'd1,
      ALU_AND = 2'd2,
      ALU_XOR = 2'd3
   } alu_op_e;

   typedef struct packed {
      logic  valid;
      pc_t   next_pc;
      word_t instr;
   } if_id_t;

   typedef struct packed {
      logic     valid;
      alu_op_e  alu_op;
      logic     use_imm;
      word_t    op_a;
      word_t    op_b;
      word_t    imm;
      word_t    store_data;
      reg_idx_t rd;
      logic     reg_write;
      logic     mem_read;
      logic     mem_write;
      logic     halt;
   } id_ex_t;

   typedef struct packed {
      logic     valid;
      word_t    alu_result;
      word_t    store_data;
      reg_idx_t rd;
      logic     reg_write;
      logic     mem_read;
      logic     mem_write;
      logic     halt;
   } ex_mem_t;

   typedef struct packed {
      logic     valid;
      word_t    data;
      reg_idx_t rd;
      logic     reg_write;
      logic     halt;
   } mem_wb_t;

endpackage

/* fetch.sv */
// Fetch stage
// Program counter, instruction memory with a load port, and the IF/ID register
`timescale 1ns/1ps
`include "proc_params.svh"

module fetch import proc_pkg::*; (
   input  logic   clk,
   input  logic   rst_n_i,
   input  logic   stall_i,
   input  logic   redirect_i,
   input  pc_t    target_i,
   input  logic   fetch_stop_i,
   input  logic   imem_we_i,
   input  pc_t    imem_addr_i,
   input  word_t  imem_wdata_i,
   output if_id_t if_id_o
);

   word_t  imem [`PROC_IMEM_DEPTH];
   pc_t    pc_q;
   pc_t    pc_plus1;
   if_id_t if_id_q;

   assign pc_plus1 = pc_q + 1'b1;

   // Program load port used while reset is held
   always_ff @(posedge clk) begin
      if (imem_we_i) begin
         imem[imem_addr_i] <= imem_wdata_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         pc_q <= '0;
      end else if (redirect_i) begin
         pc_q <= target_i;
      end else if (!stall_i && !fetch_stop_i) begin
         pc_q <= pc_plus1;
      end
   end

   // The word behind a redirect or a HALT is dropped
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         if_id_q.valid <= 1'b0;
      end else if (redirect_i || fetch_stop_i) begin
         if_id_q.valid <= 1'b0;
      end else if (!stall_i) begin
         if_id_q.valid   <= 1'b1;
         if_id_q.next_pc <= pc_plus1;
         if_id_q.instr   <= imem[pc_q];
      end
   end

   assign if_id_o = if_id_q;

   // Decode only redirects with an instruction that is free to issue
   a_no_redirect_on_stall: assert property (
      @(posedge clk) disable iff (!rst_n_i) !(redirect_i && stall_i)
   ) else $error("fetch saw redirect and stall together");

endmodule

/* decode.sv */
// Decode stage
// Control decode, register file with write-through, RAW interlock,
// branch and jump resolution, sticky error and halt, and the ID/EX register
`timescale 1ns/1ps
`include "proc_params.svh"

module decode import proc_pkg::*; (
   input  logic    clk,
   input  logic    rst_n_i,
   input  if_id_t  if_id_i,
   input  ex_mem_t ex_mem_i,
   input  mem_wb_t mem_wb_i,
   output id_ex_t  id_ex_o,
   output logic    stall_o,
   output logic    redirect_o,
   output pc_t     target_o,
   output logic    fetch_stop_o,
   output logic    err_o,
   output logic    halt_o
);

   word_t    regs [`PROC_NREGS];
   opcode_e  opcode;
   reg_idx_t rd;
   reg_idx_t rs;
   reg_idx_t rt;
   word_t    imm6_ext;
   word_t    imm12_ext;
   word_t    br_offset;
   word_t    rd_val;
   word_t    rs_val;
   word_t    rt_val;
   logic     wb_we;
   logic     issue;
   logic     taken;
   alu_op_e  ctl_alu_op;
   logic     ctl_use_imm;
   logic     ctl_reg_write;
   logic     ctl_mem_read;
   logic     ctl_mem_write;
   logic     ctl_halt;
   logic     ctl_illegal;
   logic     is_beqz;
   logic     is_j;
   logic     use_rd;
   logic     use_rs;
   logic     use_rt;
   id_ex_t   id_ex_q;
   logic     err_q;
   logic     halt_q;
   logic     halt_seen_q;

   // True when an older instruction still in flight will write idx
   function automatic logic pending_write(input reg_idx_t idx, input id_ex_t ex,
                                          input ex_mem_t mem);
      return (ex.valid && ex.reg_write && ex.rd == idx) ||
             (mem.valid && mem.reg_write && mem.rd == idx);
   endfunction

   assign opcode    = opcode_e'(if_id_i.instr[`PROC_XLEN-1:`PROC_OP_LSB]);
   assign rd        = if_id_i.instr[`PROC_RD_LSB +: `PROC_REG_AW];
   assign rs        = if_id_i.instr[`PROC_RS_LSB +: `PROC_REG_AW];
   assign rt        = if_id_i.instr[`PROC_RT_LSB +: `PROC_REG_AW];
   assign imm6_ext  = {{(`PROC_XLEN-6){if_id_i.instr[5]}}, if_id_i.instr[5:0]};
   assign imm12_ext = {{(`PROC_XLEN-12){if_id_i.instr[11]}}, if_id_i.instr[11:0]};

   always_comb begin
      ctl_alu_op    = ALU_ADD;
      ctl_use_imm   = 1'b0;
      ctl_reg_write = 1'b0;
      ctl_mem_read  = 1'b0;
      ctl_mem_write = 1'b0;
      ctl_halt      = 1'b0;
      ctl_illegal   = 1'b0;
      is_beqz       = 1'b0;
      is_j          = 1'b0;
      use_rd        = 1'b0;
      use_rs        = 1'b0;
      use_rt        = 1'b0;
      case (opcode)
         OP_NOP: ;
         OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
            ctl_alu_op    = alu_op_e'(opcode - OP_ADD);
            ctl_reg_write = 1'b1;
            use_rs        = 1'b1;
            use_rt        = 1'b1;
         end
         OP_ADDI, OP_LD: begin
            ctl_use_imm   = 1'b1;
            ctl_reg_write = 1'b1;
            ctl_mem_read  = (opcode == OP_LD);
            use_rs        = 1'b1;
         end
         OP_ST: begin
            ctl_use_imm   = 1'b1;
            ctl_mem_write = 1'b1;
            use_rs        = 1'b1;
            use_rd        = 1'b1;
         end
         OP_BEQZ: begin
            is_beqz = 1'b1;
            use_rd  = 1'b1;
         end
         OP_J:    is_j = 1'b1;
         OP_HALT: ctl_halt = 1'b1;
         default: ctl_illegal = 1'b1;
      endcase
   end

   // Register file with a MEM/WB write visible to a read in the same cycle
   assign wb_we = mem_wb_i.valid && mem_wb_i.reg_write;

   always_ff @(posedge clk) begin
      if (wb_we) begin
         regs[mem_wb_i.rd] <= mem_wb_i.data;
      end
   end

   assign rd_val = (wb_we && mem_wb_i.rd == rd) ? mem_wb_i.data : regs[rd];
   assign rs_val = (wb_we && mem_wb_i.rd == rs) ? mem_wb_i.data : regs[rs];
   assign rt_val = (wb_we && mem_wb_i.rd == rt) ? mem_wb_i.data : regs[rt];

   // No forwarding, so wait until the producer reaches MEM/WB
   assign stall_o = if_id_i.valid &&
                    ((use_rs && pending_write(rs, id_ex_q, ex_mem_i)) ||
                     (use_rt && pending_write(rt, id_ex_q, ex_mem_i)) ||
                     (use_rd && pending_write(rd, id_ex_q, ex_mem_i)));
   assign issue   = if_id_i.valid && !stall_o;

   assign taken      = is_j || (is_beqz && rd_val == '0);
   assign br_offset  = is_j ? imm12_ext : imm6_ext;
   assign target_o   = if_id_i.next_pc + br_offset[`PROC_IMEM_AW-1:0];
   assign redirect_o = issue && taken;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         id_ex_q.valid <= 1'b0;
      end else begin
         id_ex_q.valid <= issue;
      end
      id_ex_q.alu_op     <= ctl_alu_op;
      id_ex_q.use_imm    <= ctl_use_imm;
      id_ex_q.op_a       <= rs_val;
      id_ex_q.op_b       <= rt_val;
      id_ex_q.imm        <= imm6_ext;
      id_ex_q.store_data <= rd_val;
      id_ex_q.rd         <= rd;
      id_ex_q.reg_write  <= ctl_reg_write;
      id_ex_q.mem_read   <= ctl_mem_read;
      id_ex_q.mem_write  <= ctl_mem_write;
      id_ex_q.halt       <= ctl_halt;
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         err_q       <= 1'b0;
         halt_q      <= 1'b0;
         halt_seen_q <= 1'b0;
      end else begin
         if (issue && ctl_illegal) begin
            err_q <= 1'b1;
         end
         if (issue && ctl_halt) begin
            halt_seen_q <= 1'b1;
         end
         if (mem_wb_i.valid && mem_wb_i.halt) begin
            halt_q <= 1'b1;
         end
      end
   end

   assign id_ex_o      = id_ex_q;
   assign err_o        = err_q;
   assign halt_o       = halt_q;
   // Also high in the HALT's own decode cycle, so the next word is dropped
   assign fetch_stop_o = halt_seen_q || (issue && ctl_halt);

   // A stalled word waits in IF/ID while only a bubble reaches execute
   a_bubble_not_valid: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      stall_o |=> !id_ex_o.valid && $stable(if_id_i)
   ) else $error("stalled instruction left IF/ID or entered ID/EX as valid");

endmodule

/* execute.sv */
// Execute stage
// ALU with immediate operand select, and the EX/MEM register
`timescale 1ns/1ps

module execute import proc_pkg::*; (
   input  logic    clk,
   input  logic    rst_n_i,
   input  id_ex_t  id_ex_i,
   output ex_mem_t ex_mem_o
);

   word_t   src_b;
   word_t   alu_res;
   ex_mem_t ex_mem_q;

   // Immediate also forms the address for LD and ST
   assign src_b = id_ex_i.use_imm ? id_ex_i.imm : id_ex_i.op_b;

   always_comb begin
      unique case (id_ex_i.alu_op)
         ALU_ADD: alu_res = id_ex_i.op_a + src_b;
         ALU_SUB: alu_res = id_ex_i.op_a - src_b;
         ALU_AND: alu_res = id_ex_i.op_a & src_b;
         ALU_XOR: alu_res = id_ex_i.op_a ^ src_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ex_mem_q.valid <= 1'b0;
      end else begin
         ex_mem_q.valid <= id_ex_i.valid;
      end
      ex_mem_q.alu_result <= alu_res;
      ex_mem_q.store_data <= id_ex_i.store_data;
      ex_mem_q.rd         <= id_ex_i.rd;
      ex_mem_q.reg_write  <= id_ex_i.reg_write;
      ex_mem_q.mem_read   <= id_ex_i.mem_read;
      ex_mem_q.mem_write  <= id_ex_i.mem_write;
      ex_mem_q.halt       <= id_ex_i.halt;
   end

   assign ex_mem_o = ex_mem_q;

endmodule

/* memory.sv */
// Memory stage
// Data memory addressed by the ALU result, load data select and the MEM/WB register
`timescale 1ns/1ps
`include "proc_params.svh"

module memory import proc_pkg::*; (
   input  logic    clk,
   input  logic    rst_n_i,
   input  ex_mem_t ex_mem_i,
   output mem_wb_t mem_wb_o
);

   word_t                   dmem [`PROC_DMEM_DEPTH];
   logic [`PROC_DMEM_AW-1:0] addr;
   logic                    mem_we;
   word_t                   rdata;
   mem_wb_t                 mem_wb_q;

   assign addr   = ex_mem_i.alu_result[`PROC_DMEM_AW-1:0];
   assign mem_we = ex_mem_i.valid && ex_mem_i.mem_write;

   always_ff @(posedge clk) begin
      if (mem_we) begin
         dmem[addr] <= ex_mem_i.store_data;
      end
   end

   // Asynchronous read
   assign rdata = dmem[addr];

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         mem_wb_q.valid <= 1'b0;
      end else begin
         mem_wb_q.valid <= ex_mem_i.valid;
      end
      mem_wb_q.data      <= ex_mem_i.mem_read ? rdata : ex_mem_i.alu_result;
      mem_wb_q.rd        <= ex_mem_i.rd;
      mem_wb_q.reg_write <= ex_mem_i.reg_write;
      mem_wb_q.halt      <= ex_mem_i.halt;
   end

   assign mem_wb_o = mem_wb_q;

   // Addresses computed in execute must stay inside the data memory
   a_addr_in_range: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      (ex_mem_i.valid && (ex_mem_i.mem_read || ex_mem_i.mem_write)) |->
         ex_mem_i.alu_result[`PROC_XLEN-1:`PROC_DMEM_AW] == '0
   ) else $error("data memory access above the top address");

endmodule

/* proc.sv */
// Top level of the 16-bit five-stage pipelined processor
// Chains fetch, decode, execute and memory, and exposes retiring register writes
`timescale 1ns/1ps

module proc import proc_pkg::*; (
   input  logic     clk,
   input  logic     rst_n_i,
   input  logic     imem_we_i,
   input  pc_t      imem_addr_i,
   input  word_t    imem_wdata_i,
   output logic     wb_valid_o,
   output reg_idx_t wb_rd_o,
   output word_t    wb_data_o,
   output logic     halt_o,
   output logic     err_o
);

   if_id_t  if_id;
   id_ex_t  id_ex;
   ex_mem_t ex_mem;
   mem_wb_t mem_wb;

   // Decode to fetch feedback
   logic    stall;
   logic    redirect;
   pc_t     target;
   logic    fetch_stop;

   fetch fetch_blk (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .stall_i      (stall),
      .redirect_i   (redirect),
      .target_i     (target),
      .fetch_stop_i (fetch_stop),
      .imem_we_i    (imem_we_i),
      .imem_addr_i  (imem_addr_i),
      .imem_wdata_i (imem_wdata_i),
      .if_id_o      (if_id)
   );

   decode decode_blk (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .if_id_i      (if_id),
      .ex_mem_i     (ex_mem),
      .mem_wb_i     (mem_wb),
      .id_ex_o      (id_ex),
      .stall_o      (stall),
      .redirect_o   (redirect),
      .target_o     (target),
      .fetch_stop_o (fetch_stop),
      .err_o        (err_o),
      .halt_o       (halt_o)
   );

   execute execute_blk (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .id_ex_i  (id_ex),
      .ex_mem_o (ex_mem)
   );

   memory memory_blk (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .ex_mem_i (ex_mem),
      .mem_wb_o (mem_wb)
   );

   // Only register writes are reported
   assign wb_valid_o = mem_wb.valid && mem_wb.reg_write;
   assign wb_rd_o    = mem_wb.rd;
   assign wb_data_o  = mem_wb.data;

endmodule

/* tb_proc.sv */
// Directed testbench for the five-stage processor
// An instruction-set model predicts the retiring register writes of each program
`timescale 1ns/1ps
`include "proc_params.svh"

module tb_proc import proc_pkg::*; ();

   localparam int NUM_TESTS = 6;

   logic     clk;
   logic     rst_n_i;
   logic     imem_we_i;
   pc_t      imem_addr_i;
   word_t    imem_wdata_i;
   logic     wb_valid_o;
   reg_idx_t wb_rd_o;
   word_t    wb_data_o;
   logic     halt_o;
   logic     err_o;

   word_t    prog [$];
   reg_idx_t exp_rd [$];
   word_t    exp_data [$];
   logic     exp_err;
   string    test_name;

   proc DUT (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .imem_we_i    (imem_we_i),
      .imem_addr_i  (imem_addr_i),
      .imem_wdata_i (imem_wdata_i),
      .wb_valid_o   (wb_valid_o),
      .wb_rd_o      (wb_rd_o),
      .wb_data_o    (wb_data_o),
      .halt_o       (halt_o),
      .err_o        (err_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_word(input string what, input word_t exp, input word_t act);
      if (act !== exp) begin
         fail_run($sformatf("[ERROR] %s %s: expected %h, actual %h",
                            test_name, what, exp, act));
      end
   endtask

   task automatic check_reg(input string what, input reg_idx_t exp, input reg_idx_t act);
      if (act !== exp) begin
         fail_run($sformatf("[ERROR] %s %s: expected r%0d, actual r%0d",
                            test_name, what, exp, act));
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         fail_run($sformatf("[ERROR] %s %s: expected %b, actual %b",
                            test_name, what, exp, act));
      end
   endtask

   // Instruction encoders truncate register numbers and immediates to field width
   function automatic word_t r_type(input opcode_e op, input int rd, input int rs,
                                    input int rt);
      return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
   endfunction

   function automatic word_t i_type(input opcode_e op, input int rd, input int rs,
                                    input int imm);
      return {op, rd[2:0], rs[2:0], imm[5:0]};
   endfunction

   function automatic word_t j_type(input int imm);
      return {OP_J, imm[11:0]};
   endfunction

   task automatic emit(input word_t w);
      prog.push_back(w);
   endtask

   // Runs the program on an architectural model and records the expected writes
   task automatic run_model();
      word_t    regs [`PROC_NREGS];
      word_t    dmem [`PROC_DMEM_DEPTH];
      word_t    w;
      word_t    imm6;
      word_t    imm12;
      word_t    addr;
      word_t    res;
      reg_idx_t rd;
      reg_idx_t rs;
      reg_idx_t rt;
      pc_t      pc;
      pc_t      npc;
      logic     wr;
      logic     halted;
      int       steps;
      foreach (regs[i]) regs[i] = '0;
      foreach (dmem[i]) dmem[i] = '0;
      exp_rd.delete();
      exp_data.delete();
      exp_err = 1'b0;
      pc = '0;
      halted = 1'b0;
      steps = 0;
      while (!halted) begin
         if (steps > 1000 || int'(pc) >= prog.size()) begin
            fail_run("reference model ran past the end of the program without a HALT");
         end
         w     = prog[pc];
         rd    = w[11:9];
         rs    = w[8:6];
         rt    = w[5:3];
         imm6  = {{10{w[5]}}, w[5:0]};
         imm12 = {{4{w[11]}}, w[11:0]};
         addr  = regs[rs] + imm6;
         npc   = pc + 8'd1;
         wr    = 1'b0;
         res   = '0;
         case (w[15:12])
            OP_NOP: ;
            OP_ADD: begin
               res = regs[rs] + regs[rt];
               wr  = 1'b1;
            end
            OP_SUB: begin
               res = regs[rs] - regs[rt];
               wr  = 1'b1;
            end
            OP_AND: begin
               res = regs[rs] & regs[rt];
               wr  = 1'b1;
            end
            OP_XOR: begin
               res = regs[rs] ^ regs[rt];
               wr  = 1'b1;
            end
            OP_ADDI: begin
               res = addr;
               wr  = 1'b1;
            end
            OP_LD: begin
               res = dmem[addr[`PROC_DMEM_AW-1:0]];
               wr  = 1'b1;
            end
            OP_ST:   dmem[addr[`PROC_DMEM_AW-1:0]] = regs[rd];
            OP_BEQZ: if (regs[rd] == '0) npc = npc + imm6[7:0];
            OP_J:    npc = npc + imm12[7:0];
            OP_HALT: halted = 1'b1;
            default: exp_err = 1'b1;
         endcase
         if (wr) begin
            regs[rd] = res;
            exp_rd.push_back(rd);
            exp_data.push_back(res);
         end
         pc = npc;
         steps++;
      end
   endtask

   // Reset for 10 cycles, load the program while still in reset, then release
   task automatic load_and_start();
      @(posedge clk);
      #1;
      rst_n_i = 1'b0;
      repeat (10) begin
         @(posedge clk);
         #1;
      end
      for (int i = 0; i < prog.size(); i++) begin
         imem_we_i    = 1'b1;
         imem_addr_i  = pc_t'(i);
         imem_wdata_i = prog[i];
         @(posedge clk);
         #1;
      end
      imem_we_i = 1'b0;
      check_bit("err_o after reset", 1'b0, err_o);
      check_bit("halt_o after reset", 1'b0, halt_o);
      check_bit("wb_valid_o after reset", 1'b0, wb_valid_o);
      rst_n_i = 1'b1;
   endtask

   // Compares each retiring write against the model until the HALT retires
   task automatic follow_retirement();
      logic done;
      logic err_seen;
      done = 1'b0;
      err_seen = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (err_seen && err_o !== 1'b1) begin
            fail_run($sformatf("%s: err_o dropped after it was set", test_name));
         end
         err_seen = (err_o === 1'b1);
         if (wb_valid_o === 1'b1) begin
            if (exp_rd.size() == 0) begin
               fail_run($sformatf("%s: register write to r%0d after all expected writes",
                                  test_name, wb_rd_o));
            end
            check_reg("wb_rd_o", exp_rd.pop_front(), wb_rd_o);
            check_word("wb_data_o", exp_data.pop_front(), wb_data_o);
         end
         if (halt_o === 1'b1) begin
            if (exp_rd.size() != 0) begin
               fail_run($sformatf("%s: halt_o rose with %0d expected writes still missing",
                                  test_name, exp_rd.size()));
            end
            done = 1'b1;
         end
      end
      // Nothing behind the HALT may retire
      repeat (8) begin
         @(negedge clk);
         check_bit("wb_valid_o after halt", 1'b0, wb_valid_o);
         check_bit("halt_o held", 1'b1, halt_o);
      end
      check_bit("err_o", exp_err, err_o);
   endtask

   task automatic run_program(input string name);
      test_name = name;
      run_model();
      load_and_start();
      follow_retirement();
   endtask

   task automatic reset_then_halt();
      prog.delete();
      repeat (3) emit(r_type(OP_NOP, 0, 0, 0));
      emit(r_type(OP_HALT, 0, 0, 0));
      run_program("reset_then_halt");
   endtask

   // Register contents survive reset, so every test clears what it reads with XOR
   task automatic alu_chain();
      prog.delete();
      emit(r_type(OP_XOR, 1, 1, 1));
      emit(i_type(OP_ADDI, 1, 1, 5));
      emit(i_type(OP_ADDI, 2, 1, -3));
      emit(r_type(OP_ADD, 3, 1, 2));
      emit(r_type(OP_SUB, 4, 3, 1));
      emit(r_type(OP_AND, 5, 4, 3));
      emit(r_type(OP_XOR, 6, 5, 3));
      emit(i_type(OP_ADDI, 7, 6, 31));
      emit(r_type(OP_SUB, 0, 2, 7));
      emit(r_type(OP_HALT, 0, 0, 0));
      run_program("alu_chain");
   endtask

   task automatic load_after_store();
      prog.delete();
      emit(r_type(OP_XOR, 1, 1, 1));
      emit(i_type(OP_ADDI, 1, 1, 20));
      emit(i_type(OP_ADDI, 2, 1, -7));
      emit(i_type(OP_ST, 2, 1, 3));
      emit(i_type(OP_LD, 3, 1, 3));
      emit(r_type(OP_ADD, 4, 3, 3));
      emit(i_type(OP_ST, 4, 1, -4));
      emit(i_type(OP_LD, 5, 1, -4));
      emit(r_type(OP_XOR, 6, 5, 2));
      emit(r_type(OP_HALT, 0, 0, 0));
      run_program("load_after_store");
   endtask

   task automatic branches_and_jumps();
      prog.delete();
      emit(r_type(OP_XOR, 1, 1, 1));
      emit(i_type(OP_ADDI, 2, 1, 1));
      emit(i_type(OP_BEQZ, 2, 0, 2));
      emit(i_type(OP_ADDI, 3, 1, 3));
      emit(i_type(OP_BEQZ, 1, 0, 2));
      emit(i_type(OP_ADDI, 4, 1, 4));
      emit(i_type(OP_ADDI, 4, 1, 6));
      emit(i_type(OP_ADDI, 5, 1, 7));
      emit(j_type(2));
      emit(i_type(OP_ADDI, 6, 1, 9));
      emit(i_type(OP_ADDI, 6, 1, 10));
      emit(i_type(OP_ADDI, 7, 1, 11));
      // Countdown loop with a backward jump
      emit(i_type(OP_ADDI, 2, 1, 3));
      emit(i_type(OP_ADDI, 2, 2, -1));
      emit(i_type(OP_BEQZ, 2, 0, 1));
      emit(j_type(-3));
      emit(r_type(OP_HALT, 0, 0, 0));
      emit(i_type(OP_ADDI, 0, 1, 1));
      run_program("branches_and_jumps");
   endtask

   task automatic illegal_opcode();
      prog.delete();
      emit(r_type(OP_XOR, 1, 1, 1));
      emit(i_type(OP_ADDI, 1, 1, 9));
      // Opcodes 11 and 14 are unassigned
      emit(16'hb249);
      emit(i_type(OP_ADDI, 2, 1, 4));
      emit(16'he000);
      emit(r_type(OP_ADD, 3, 2, 1));
      emit(r_type(OP_HALT, 0, 0, 0));
      run_program("illegal_opcode");
   endtask

   task automatic random_alu_program();
      opcode_e ops [5] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI};
      int      k;
      prog.delete();
      for (int r = 0; r < `PROC_NREGS; r++) begin
         emit(r_type(OP_XOR, r, r, r));
      end
      for (int n = 0; n < 40; n++) begin
         k = $urandom_range(4, 0);
         if (ops[k] == OP_ADDI) begin
            emit(i_type(OP_ADDI, $urandom_range(7, 0), $urandom_range(7, 0),
                        $urandom_range(63, 0)));
         end else begin
            emit(r_type(ops[k], $urandom_range(7, 0), $urandom_range(7, 0),
                        $urandom_range(7, 0)));
         end
      end
      emit(r_type(OP_HALT, 0, 0, 0));
      run_program("random_alu_program");
   endtask

   // Watchdog sized from the number of tests
   initial begin
      repeat (NUM_TESTS * 400) @(posedge clk);
      fail_run("timeout, the tests did not finish within the cycle budget");
   end

   initial begin
      rst_n_i      = 1'b0;
      imem_we_i    = 1'b0;
      imem_addr_i  = '0;
      imem_wdata_i = '0;
      void'($urandom(32'hb2e4_caf9));
      reset_then_halt();
      alu_chain();
      load_after_store();
      branches_and_jumps();
      illegal_opcode();
      random_alu_program();
      $display("Verification passed");
      $finish;
   end

endmodule

/* proc.f */
+incdir+.
proc_pkg.sv
fetch.sv
decode.sv
execute.sv
memory.sv
proc.sv
tb_proc.sv

/* Makefile */
# Verilator build and run of the proc testbench

VERILATOR ?= verilator
TOP       ?= tb_proc
FILELIST  ?= proc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
